// File: video_top.f
+incdir+hw
hw/video_pkg.sv
hw/ppu_capture.sv
hw/line_fifo.sv
hw/tft_scan.sv
hw/video_top.sv
dv/video_top_assert.sv
dv/video_top_tb.sv

// File: Makefile
# Verilator simulation of the video path

VERILATOR ?= verilator
TOP ?= video_top_tb
FLIST ?= video_top.f
BUILD ?= obj_dir
SEED_ARGS ?=
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD)

// File: dv/video_top_tb.sv
// PPU stimulus is aligned to the free running raster from reset; frames follow a fixed mode list
`timescale 1ns/1ps
`include "video_defines.svh"

bind video_top video_top_assert chk0 (
	.clk10M(clk10M),
	.reset(reset),
	.cap_entry(cap_entry),
	.cap_valid(cap_valid),
	.cap_ready(cap_ready),
	.scan_entry(scan_entry),
	.scan_valid(scan_valid),
	.scan_ready(scan_ready),
	.tft_de(tft_de),
	.tft_hsync(tft_hsync),
	.tft_vsync(tft_vsync)
);

module video_top_tb;

	localparam int LINE = `VID_H_TOTAL;
	localparam int FRAME = LINE * `VID_V_TOTAL;
	localparam int ACT_END = `VID_V_ACTIVE * LINE;
	// Raster starts at the first blanking line; one cycle for the counter, two for the path
	localparam int OFFSET = ACT_END + 3;
	// Vblank falls at the start of the last back porch line, after the disarm point
	localparam int MARK_Q = FRAME - LINE;
	localparam int NFRAMES = 7;
	localparam int N_END = NFRAMES * FRAME - OFFSET + ACT_END + 10;
	localparam int TIMEOUT_CYCLES = NFRAMES * FRAME + 600;
	localparam int MODE_NORMAL = 0;
	localparam int MODE_SHORT = 1;
	localparam int MODE_LONG = 2;

	logic clk10M;
	logic reset;
	logic [23:0] ppu_rgb;
	logic ppu_valid;
	logic ppu_vblank;
	logic [23:0] tft_rgb;
	logic tft_de;
	logic tft_hsync;
	logic tft_vsync;
	logic overflow;
	logic underflow;
	logic [`VID_SEQ_W - 1:0] frame_seq;

	logic [23:0] exp_q [$];
	logic [23:0] exp_pix;
	logic [23:0] pix;
	logic [31:0] rnd_state;
	logic [`VID_SEQ_W - 1:0] falls;
	logic running;
	logic exp_over;
	logic exp_under;
	int frame_mode [NFRAMES];
	int q;
	int fr;
	int line;
	int col;
	logic in_act;
	logic drive_pix;

	// Panel timing monitor state
	int de_run;
	int de_lines;
	int hs_run;
	int hs_gap;
	int vs_run;
	int vs_gap;
	logic hs_seen;
	logic vs_seen;
	logic prev_de;
	logic prev_hs;
	logic prev_vs;

	video_top uut (
		.clk10M(clk10M),
		.reset(reset),
		.ppu_rgb(ppu_rgb),
		.ppu_valid(ppu_valid),
		.ppu_vblank(ppu_vblank),
		.tft_rgb(tft_rgb),
		.tft_de(tft_de),
		.tft_hsync(tft_hsync),
		.tft_vsync(tft_vsync),
		.overflow(overflow),
		.underflow(underflow),
		.frame_seq(frame_seq)
	);

	always #50 clk10M = ~clk10M;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 24 bits down to RGB565, then each channel refilled below with its own top bits
	function automatic logic [23:0] convert_pixel(input logic [23:0] p);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = {p[23:19], 3'b000};
		g = {p[15:10], 2'b00};
		b = {p[7:3], 3'b000};
		r = r | (r >> 5);
		g = g | (g >> 6);
		b = b | (b >> 5);
		return {r, g, b};
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
	endtask

	task automatic check_idle(input string when);
		assert (!tft_de && !tft_hsync && !tft_vsync && !overflow && !underflow
			&& tft_rgb == 24'h0 && frame_seq == {`VID_SEQ_W{1'b0}})
		else begin
			report_fail($sformatf(
				"Fail idle %s: expected de/hs/vs/ov/un %b rgb %h seq %h, actual %b rgb %h seq %h",
				when, 5'b00000, 24'h0, {`VID_SEQ_W{1'b0}},
				{tft_de, tft_hsync, tft_vsync, overflow, underflow}, tft_rgb, frame_seq));
			$fatal(1);
		end
	endtask

	initial begin
		clk10M = 1'b0;
		reset = 1'b1;
		ppu_rgb = 24'h0;
		ppu_valid = 1'b0;
		ppu_vblank = 1'b0;
		rnd_state = 32'h28de;
		falls = '0;
		running = 1'b0;
		exp_over = 1'b0;
		exp_under = 1'b0;
		frame_mode[0] = MODE_NORMAL;
		frame_mode[1] = MODE_NORMAL;
		frame_mode[2] = MODE_SHORT;
		frame_mode[3] = MODE_NORMAL;
		frame_mode[4] = MODE_LONG;
		frame_mode[5] = MODE_NORMAL;
		frame_mode[6] = MODE_NORMAL;

		@(posedge clk10M);
		@(posedge clk10M);
		check_idle("during reset");
		reset <= 1'b0;

		for (int n = 0; n <= N_END; n++) begin
			@(posedge clk10M);
			if (n == 0)
				running <= 1'b1;
			if (n < 2)
				check_idle("right after reset");
			q = (n + OFFSET) % FRAME;
			fr = (n + OFFSET) / FRAME - 1;
			line = q / LINE;
			col = q % LINE;
			in_act = (q < ACT_END) && (col < `VID_H_ACTIVE);
			drive_pix = 1'b0;

			// Frame start: marker count and flags
			if (q == 0 && fr >= 0 && fr < NFRAMES) begin
				if (fr > 0 && frame_mode[fr - 1] == MODE_SHORT)
					exp_under = 1'b1;
				if (fr > 0 && frame_mode[fr - 1] == MODE_LONG)
					exp_over = 1'b1;
				assert (frame_seq == falls)
				else begin
					report_fail($sformatf("Fail frame_seq: expected %h, actual %h",
						falls, frame_seq));
					$fatal(1);
				end
				assert (overflow == exp_over && underflow == exp_under)
				else begin
					report_fail($sformatf("Fail flags: expected %b%b, actual %b%b",
						exp_over, exp_under, overflow, underflow));
					$fatal(1);
				end
			end

			if (fr >= 0 && fr < NFRAMES) begin
				if (in_act) begin
					// Short frame leaves its last line out
					if (frame_mode[fr] == MODE_SHORT && line == `VID_V_ACTIVE - 1)
						exp_q.push_back(24'h0);
					else
						drive_pix = 1'b1;
				end else if (frame_mode[fr] == MODE_LONG && q <= MARK_Q) begin
					// Extra pixels run into blanking and over the next vblank edge
					drive_pix = 1'b1;
				end
			end

			if (drive_pix) begin
				rnd_state = next_random(rnd_state);
				pix = rnd_state[23:0];
				ppu_rgb <= pix;
				ppu_valid <= 1'b1;
				if (in_act)
					exp_q.push_back(convert_pixel(pix));
			end else begin
				ppu_valid <= 1'b0;
			end

			ppu_vblank <= (q >= ACT_END) && (q < MARK_Q);
			if (q == MARK_Q)
				falls = falls + 1'b1;
		end

		ppu_valid <= 1'b0;
		@(posedge clk10M);
		assert (exp_q.size() == 0)
		else begin
			report_fail($sformatf("Pixels still expected at the end: %0d", exp_q.size()));
			$fatal(1);
		end
		assert (overflow && underflow)
		else begin
			report_fail($sformatf("Fail final flags: expected 11, actual %b%b",
				overflow, underflow));
			$fatal(1);
		end
		$display("RESULT: PASS");
		$finish;
	end

	// Compare every displayed pixel and watch the panel timing
	always @(posedge clk10M) begin
		if (running) begin
			if (tft_de) begin
				assert (exp_q.size() > 0)
				else begin
					report_fail("Data enable was high with no pixel expected");
					$fatal(1);
				end
				exp_pix = exp_q.pop_front();
				assert (tft_rgb == exp_pix)
				else begin
					report_fail($sformatf("Fail colour: expected %h, actual %h",
						exp_pix, tft_rgb));
					$fatal(1);
				end
				de_run = de_run + 1;
			end else begin
				assert (tft_rgb == 24'h0)
				else begin
					report_fail($sformatf("Fail blank colour: expected %h, actual %h",
						24'h0, tft_rgb));
					$fatal(1);
				end
				if (prev_de) begin
					assert (de_run == `VID_H_ACTIVE)
					else begin
						report_fail($sformatf("Fail de width: expected %0d, actual %0d",
							`VID_H_ACTIVE, de_run));
						$fatal(1);
					end
					de_run = 0;
					de_lines = de_lines + 1;
				end
			end

			hs_gap = hs_gap + 1;
			if (tft_hsync)
				hs_run = hs_run + 1;
			if (tft_hsync && !prev_hs) begin
				assert (!hs_seen || hs_gap == LINE)
				else begin
					report_fail($sformatf("Fail hsync period: expected %0d, actual %0d",
						LINE, hs_gap));
					$fatal(1);
				end
				hs_gap = 0;
				hs_seen = 1'b1;
			end
			if (!tft_hsync && prev_hs) begin
				assert (hs_run == `VID_H_SYNC)
				else begin
					report_fail($sformatf("Fail hsync width: expected %0d, actual %0d",
						`VID_H_SYNC, hs_run));
					$fatal(1);
				end
				hs_run = 0;
			end

			vs_gap = vs_gap + 1;
			if (tft_vsync)
				vs_run = vs_run + 1;
			if (tft_vsync && !prev_vs) begin
				assert (!vs_seen || (vs_gap == FRAME && de_lines == `VID_V_ACTIVE))
				else begin
					report_fail($sformatf("Fail frame: expected %0d/%0d, actual %0d/%0d",
						FRAME, `VID_V_ACTIVE, vs_gap, de_lines));
					$fatal(1);
				end
				vs_gap = 0;
				de_lines = 0;
				vs_seen = 1'b1;
			end
			if (!tft_vsync && prev_vs) begin
				assert (vs_run == `VID_V_SYNC * LINE)
				else begin
					report_fail($sformatf("Fail vsync width: expected %0d, actual %0d",
						`VID_V_SYNC * LINE, vs_run));
					$fatal(1);
				end
				vs_run = 0;
			end
		end
		prev_de = tft_de;
		prev_hs = tft_hsync;
		prev_vs = tft_vsync;
	end

	initial begin
		de_run = 0;
		de_lines = 0;
		hs_run = 0;
		hs_gap = 0;
		vs_run = 0;
		vs_gap = 0;
		hs_seen = 1'b0;
		vs_seen = 1'b0;
		prev_de = 1'b0;
		prev_hs = 1'b0;
		prev_vs = 1'b0;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * 100);
		$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1);
	end

endmodule

// File: dv/video_top_assert.sv
// Handshake and sync rules, checked only outside reset; bound to every video_top instance
`timescale 1ns/1ps

module video_top_assert (
	input logic clk10M,
	input logic reset,
	input video_pkg::fb_entry_t cap_entry,
	input logic cap_valid,
	input logic cap_ready,
	input video_pkg::fb_entry_t scan_entry,
	input logic scan_valid,
	input logic scan_ready,
	input logic tft_de,
	input logic tft_hsync,
	input logic tft_vsync
);

	// Pending capture entry held until the buffer takes it
	cap_hold: assert property (@(posedge clk10M) disable iff (reset)
		cap_valid && !cap_ready |=> cap_valid && $stable(cap_entry))
		else $error("Capture entry or valid changed while the buffer was full");

	// Buffer head held until the scan takes it
	scan_hold: assert property (@(posedge clk10M) disable iff (reset)
		scan_valid && !scan_ready |=> scan_valid && $stable(scan_entry))
		else $error("Buffer head or valid changed while the scan was not reading");

	// Data enable only outside both sync pulses
	de_vs_sync: assert property (@(posedge clk10M) disable iff (reset)
		!(tft_de && (tft_hsync || tft_vsync)))
		else $error("Data enable was high during a sync pulse");

	// No read from an empty buffer
	ready_needs_valid: assert property (@(posedge clk10M) disable iff (reset)
		scan_ready |-> scan_valid)
		else $error("Scan read the buffer while it was empty");

endmodule

// File: hw/video_top.sv
// Single clock video path; buffer depth comes from VID_FIFO_DEPTH
`timescale 1ns/1ps
`include "video_defines.svh"

module video_top (
	input logic clk10M,
	input logic reset,
	input logic [23:0] ppu_rgb,
	input logic ppu_valid,
	input logic ppu_vblank,
	output logic [23:0] tft_rgb,
	output logic tft_de,
	output logic tft_hsync,
	output logic tft_vsync,
	output logic overflow,
	output logic underflow,
	output logic [`VID_SEQ_W - 1:0] frame_seq
);

	import video_pkg::*;

	// Capture to buffer
	fb_entry_t cap_entry;
	logic cap_valid;
	logic cap_ready;

	// Buffer to scan
	fb_entry_t scan_entry;
	logic scan_valid;
	logic scan_ready;

	ppu_capture cap0 (
		.clk10M(clk10M),
		.reset(reset),
		.ppu_rgb(ppu_rgb),
		.ppu_valid(ppu_valid),
		.ppu_vblank(ppu_vblank),
		.cap_entry(cap_entry),
		.cap_valid(cap_valid),
		.cap_ready(cap_ready),
		.overflow(overflow)
	);

	line_fifo #(.DEPTH(`VID_FIFO_DEPTH)) fifo0 (
		.clk10M(clk10M),
		.reset(reset),
		.in_entry(cap_entry),
		.in_valid(cap_valid),
		.in_ready(cap_ready),
		.out_entry(scan_entry),
		.out_valid(scan_valid),
		.out_ready(scan_ready)
	);

	tft_scan scan0 (
		.clk10M(clk10M),
		.reset(reset),
		.scan_entry(scan_entry),
		.scan_valid(scan_valid),
		.scan_ready(scan_ready),
		.tft_rgb(tft_rgb),
		.tft_de(tft_de),
		.tft_hsync(tft_hsync),
		.tft_vsync(tft_vsync),
		.underflow(underflow),
		.frame_seq(frame_seq)
	);

endmodule

// File: hw/tft_scan.sv
// Counters restart at the first blanking line after reset; outputs lag the counters by one cycle
`timescale 1ns/1ps
`include "video_defines.svh"

module tft_scan (
	input logic clk10M,
	input logic reset,
	input video_pkg::fb_entry_t scan_entry,
	input logic scan_valid,
	output logic scan_ready,
	output logic [23:0] tft_rgb,
	output logic tft_de,
	output logic tft_hsync,
	output logic tft_vsync,
	output logic underflow,
	output logic [`VID_SEQ_W - 1:0] frame_seq
);

	import video_pkg::*;

	localparam int HW = $clog2(`VID_H_TOTAL);
	localparam int VW = $clog2(`VID_V_TOTAL);
	localparam logic [HW - 1:0] H_ACT = HW'(`VID_H_ACTIVE);
	localparam logic [HW - 1:0] H_SYNC_ON = HW'(`VID_H_ACTIVE + `VID_H_FRONT);
	localparam logic [HW - 1:0] H_SYNC_OFF = HW'(`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC);
	localparam logic [HW - 1:0] H_LAST = HW'(`VID_H_TOTAL - 1);
	localparam logic [VW - 1:0] V_ACT = VW'(`VID_V_ACTIVE);
	localparam logic [VW - 1:0] V_SYNC_ON = VW'(`VID_V_ACTIVE + `VID_V_FRONT);
	localparam logic [VW - 1:0] V_SYNC_OFF = VW'(`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC);
	localparam logic [VW - 1:0] V_LAST = VW'(`VID_V_TOTAL - 1);

	logic [HW - 1:0] hcnt;
	logic [VW - 1:0] vcnt;
	logic active;
	logic hsync_c;
	logic vsync_c;
	logic armed;
	logic head_mark;
	logic head_pix;
	logic pop;
	logic disarm;
	rgb565_t pix;
	logic [23:0] wide;

	assign active = (hcnt < H_ACT) && (vcnt < V_ACT);
	assign hsync_c = (hcnt >= H_SYNC_ON) && (hcnt < H_SYNC_OFF);
	assign vsync_c = (vcnt >= V_SYNC_ON) && (vcnt < V_SYNC_OFF);
	// Start of the first vertical sync line
	assign disarm = (hcnt == '0) && (vcnt == V_SYNC_ON);

	assign head_mark = scan_valid & scan_entry.is_mark;
	assign head_pix = scan_valid & ~scan_entry.is_mark;

	// In blanking everything at the head is drained, pixels and markers alike
	assign pop = active ? (armed & head_pix) : scan_valid;
	assign scan_ready = pop;

	// Bit replication back to 8 bits per channel
	assign pix = scan_entry.word.pix;
	assign wide = {pix.r, pix.r[4:2], pix.g, pix.g[5:4], pix.b, pix.b[4:2]};

	// Free running raster position
	always_ff @(posedge clk10M) begin
		if (reset) begin
			hcnt <= '0;
			vcnt <= V_ACT;
		end else if (hcnt == H_LAST) begin
			hcnt <= '0;
			vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	always_ff @(posedge clk10M) begin
		if (reset) begin
			armed <= 1'b0;
			frame_seq <= '0;
			underflow <= 1'b0;
			tft_de <= 1'b0;
			tft_hsync <= 1'b0;
			tft_vsync <= 1'b0;
			tft_rgb <= '0;
		end else begin
			// A marker wins over the disarm point
			if (!active && head_mark) begin
				armed <= 1'b1;
				frame_seq <= scan_entry.word.mark.seq;
			end else if (disarm) begin
				armed <= 1'b0;
			end
			if (active && !pop)
				underflow <= 1'b1;
			tft_de <= active;
			tft_hsync <= hsync_c;
			tft_vsync <= vsync_c;
			// Black whenever no pixel is taken
			tft_rgb <= (active && pop) ? wide : 24'h0;
		end
	end

endmodule

// File: hw/line_fifo.sv
// Head is shown without a read; write and read may share a cycle even when full is not reached
`timescale 1ns/1ps
`include "video_defines.svh"

module line_fifo #(
	parameter int DEPTH = `VID_FIFO_DEPTH
) (
	input logic clk10M,
	input logic reset,
	input video_pkg::fb_entry_t in_entry,
	input logic in_valid,
	output logic in_ready,
	output video_pkg::fb_entry_t out_entry,
	output logic out_valid,
	input logic out_ready
);

	import video_pkg::*;

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW - 1:0] LAST = AW'(DEPTH - 1);
	localparam logic [CW - 1:0] FULL = CW'(DEPTH);

	fb_entry_t mem [DEPTH];
	logic [AW - 1:0] wr_ptr;
	logic [AW - 1:0] rd_ptr;
	logic [CW - 1:0] count;
	logic push;
	logic pop;

	assign in_ready = count != FULL;
	assign out_valid = count != '0;
	assign out_entry = mem[rd_ptr];

	assign push = in_valid & in_ready;
	assign pop = out_valid & out_ready;

	// Storage
	always_ff @(posedge clk10M) begin
		if (push)
			mem[wr_ptr] <= in_entry;
	end

	// Pointers wrap explicitly so any depth works
	always_ff @(posedge clk10M) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hw/ppu_capture.sv
// One pending entry only; a marker always takes the slot and any entry lost raises overflow
`timescale 1ns/1ps
`include "video_defines.svh"

module ppu_capture (
	input logic clk10M,
	input logic reset,
	input logic [23:0] ppu_rgb,
	input logic ppu_valid,
	input logic ppu_vblank,
	output video_pkg::fb_entry_t cap_entry,
	output logic cap_valid,
	input logic cap_ready,
	output logic overflow
);

	import video_pkg::*;

	logic vblank_d;
	logic [`VID_SEQ_W - 1:0] seq;
	logic [`VID_SEQ_W - 1:0] seq_next;
	logic take;
	logic room;
	logic mark_due;
	logic load_pix;
	logic lost;
	fb_entry_t mark_entry;
	fb_entry_t pix_entry;

	assign take = cap_valid & cap_ready;
	// Slot is free, or is emptied at this edge
	assign room = ~cap_valid | take;
	// End of vertical blank
	assign mark_due = vblank_d & ~ppu_vblank;
	assign load_pix = ppu_valid & room & ~mark_due;
	assign seq_next = seq + 1'b1;

	// Pixel dropped for lack of room, or pending entry overwritten by a marker
	assign lost = (ppu_valid & ~room) | (ppu_valid & mark_due) | (mark_due & ~room);

	always_comb begin
		mark_entry = '0;
		mark_entry.is_mark = 1'b1;
		mark_entry.word.mark.seq = seq_next;

		// Keep the top bits of each channel
		pix_entry = '0;
		pix_entry.word.pix.r = ppu_rgb[23:19];
		pix_entry.word.pix.g = ppu_rgb[15:10];
		pix_entry.word.pix.b = ppu_rgb[7:3];
	end

	always_ff @(posedge clk10M) begin
		if (reset) begin
			vblank_d <= 1'b0;
			seq <= '0;
			cap_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			vblank_d <= ppu_vblank;
			if (mark_due)
				seq <= seq_next;
			if (mark_due || load_pix)
				cap_valid <= 1'b1;
			else if (take)
				cap_valid <= 1'b0;
			if (lost)
				overflow <= 1'b1;
		end
	end

	// Pending entry payload
	always_ff @(posedge clk10M) begin
		if (mark_due)
			cap_entry <= mark_entry;
		else if (load_pix)
			cap_entry <= pix_entry;
	end

endmodule

// File: hw/video_pkg.sv
// Buffer word types; VID_SEQ_W must stay below 16 so the marker fits in one pixel word
`include "video_defines.svh"

package video_pkg;

	// Reduced colour as stored in the line buffer
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// Frame marker, written once per vertical blank
	typedef struct packed {
		logic [`VID_SEQ_W - 1:0] seq;
		logic [15 - `VID_SEQ_W:0] spare;
	} marker_t;

	// One buffer word, read as pixel or marker depending on the tag
	typedef union packed {
		rgb565_t pix;
		marker_t mark;
	} fb_word_u;

	// Tagged buffer entry
	typedef struct packed {
		logic is_mark;
		fb_word_u word;
	} fb_entry_t;

endpackage

// File: hw/video_defines.svh
// Small panel geometry for short simulations; the sums must stay in step with the region counts
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal regions, in pixel clocks
`define VID_H_ACTIVE 16
`define VID_H_FRONT 2
`define VID_H_SYNC 2
`define VID_H_BACK 4
`define VID_H_TOTAL (`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)

// Vertical regions, in lines
`define VID_V_ACTIVE 6
`define VID_V_FRONT 1
`define VID_V_SYNC 1
`define VID_V_BACK 2
`define VID_V_TOTAL (`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

`define VID_FIFO_DEPTH 8
`define VID_SEQ_W 8

`endif
